//--- common/fetch_pkg.sv
// shared widths, reset pc and packed structs of the fetch front end
package fetch_pkg;

    // number of barrel harts sharing the fetch slot
    localparam int unsigned NUM_HARTS = 4;

    // hart index width, 2 bits for four harts
    localparam int unsigned HART_W = $clog2(NUM_HARTS);

    // data and address width
    localparam int unsigned XLEN = 32;

    // pc of every hart after reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0200;

    // byte step between sequential instructions, no compressed ops
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;

    // hart index
    typedef logic [HART_W-1:0] hart_id_t;

    // address or instruction word
    typedef logic [XLEN-1:0] word_t;

    // instruction memory request
    typedef struct packed {
        logic  ren;
        // byte address of the fetched word
        word_t addr;
    } imem_req_t;

    // instruction memory response
    typedef struct packed {
        // wait level, read completes when low
        logic  busy;
        word_t rdata;
    } imem_rsp_t;

    // pc redirect coming back from execute
    typedef struct packed {
        logic     valid;
        hart_id_t hart;
        word_t    target;
    } redirect_t;

    // fetch to execute packet
    typedef struct packed {
        logic     valid;
        hart_id_t hart;
        word_t    pc;
        word_t    instr;
    } fetch_pkt_t;

endpackage

//--- hdl/hart_selector.sv
// round-robin hart counter stepping on every used fetch slot
`timescale 1ns/1ps

module hart_selector (
    input  logic                CLK,
    input  logic                nRST,
    // fetch slot used this cycle
    input  logic                advance,
    output fetch_pkg::hart_id_t hart_id
);

    fetch_pkg::hart_id_t count;
    fetch_pkg::hart_id_t next_count;

    // wrap after the last hart, hold when the slot was not used
    always_comb begin
        next_count = count;
        if (advance) begin
            if (count == fetch_pkg::hart_id_t'(fetch_pkg::NUM_HARTS - 1)) begin
                next_count = '0;
            end else begin
                next_count = count + fetch_pkg::hart_id_t'(1);
            end
        end
    end

    // hart 0 fetches first after reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else begin
            count <= next_count;
        end
    end

    // fixed interleave order of the barrel
    assign hart_id = count;

endmodule

//--- hdl/pc_bank.sv
// per-hart program counters with fetch increment and redirect load
`timescale 1ns/1ps

module pc_bank (
    input  logic                                          CLK,
    input  logic                                          nRST,
    // hart owning the current fetch slot
    input  fetch_pkg::hart_id_t                           hart_id,
    input  logic                                          advance,
    input  fetch_pkg::redirect_t                          redirect,
    // all hart pcs, index is the hart id
    output fetch_pkg::word_t [fetch_pkg::NUM_HARTS-1:0]   pcs
);

    fetch_pkg::word_t [fetch_pkg::NUM_HARTS-1:0] pc_q;
    fetch_pkg::word_t [fetch_pkg::NUM_HARTS-1:0] pc_d;

    // next pc of every hart
    always_comb begin
        pc_d = pc_q;
        for (int h = 0; h < fetch_pkg::NUM_HARTS; h++) begin
            // redirect checked first so it wins over the increment
            if (redirect.valid && (redirect.hart == fetch_pkg::hart_id_t'(h))) begin
                pc_d[h] = redirect.target;
            end else if (advance && (hart_id == fetch_pkg::hart_id_t'(h))) begin
                pc_d[h] = pc_q[h] + fetch_pkg::PC_STEP;
            end
        end
    end

    // every hart starts at the same boot address
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int h = 0; h < fetch_pkg::NUM_HARTS; h++) begin
                pc_q[h] <= fetch_pkg::RESET_PC;
            end
        end else begin
            pc_q <= pc_d;
        end
    end

    // read side for the fetch stage
    assign pcs = pc_q;

endmodule

//--- hdl/fetch_stage.sv
// memory request, slot advance, flush and registered fetch to execute packet
`timescale 1ns/1ps

module fetch_stage (
    input  logic                                          CLK,
    input  logic                                          nRST,
    input  fetch_pkg::hart_id_t                           hart_id,
    input  fetch_pkg::word_t [fetch_pkg::NUM_HARTS-1:0]   pcs,
    input  fetch_pkg::redirect_t                          redirect,
    input  fetch_pkg::imem_rsp_t                          imem_rsp,
    output fetch_pkg::imem_req_t                          imem_req,
    output logic                                          advance,
    output fetch_pkg::fetch_pkt_t                         fetch_pkt
);

    // read enable, low in reset and high from the first edge after it
    logic ren_q;

    // pc of the hart owning this slot
    fetch_pkg::word_t cur_pc;

    // redirect hits the hart currently fetching
    logic flush;

    // packet control
    logic pkt_valid_q;

    // packet payload
    fetch_pkg::hart_id_t pkt_hart_q;
    fetch_pkg::word_t    pkt_pc_q;
    fetch_pkg::word_t    pkt_instr_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ren_q <= 1'b0;
        end else begin
            ren_q <= 1'b1;
        end
    end

    // address follows the selected hart
    assign cur_pc = pcs[hart_id];

    // held steady by the selector and bank while busy is high
    assign imem_req.ren  = ren_q;
    assign imem_req.addr = cur_pc;

    // the word in flight is stale once its hart is redirected
    assign flush = redirect.valid && (redirect.hart == hart_id);

    // slot is used only when the read completes and is not flushed
    assign advance = ren_q && !imem_rsp.busy && !flush;

    // one packet per used slot, none on busy or flush
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pkt_valid_q <= 1'b0;
        end else begin
            pkt_valid_q <= advance;
        end
    end

    // rdata is valid only in the completing cycle, capture it there
    always_ff @(posedge CLK) begin
        if (advance) begin
            pkt_hart_q  <= hart_id;
            pkt_pc_q    <= cur_pc;
            pkt_instr_q <= imem_rsp.rdata;
        end
    end

    // packet to execute
    assign fetch_pkt.valid = pkt_valid_q;
    assign fetch_pkt.hart  = pkt_hart_q;
    assign fetch_pkt.pc    = pkt_pc_q;
    assign fetch_pkt.instr = pkt_instr_q;

endmodule

//--- hdl/fetch_top.sv
// fetch front end top with hart selector, pc bank and fetch stage
`timescale 1ns/1ps

module fetch_top (
    input  logic                  CLK,
    input  logic                  nRST,
    // instruction memory
    output fetch_pkg::imem_req_t  imem_req,
    input  fetch_pkg::imem_rsp_t  imem_rsp,
    // redirect strobe from execute
    input  fetch_pkg::redirect_t  redirect,
    // packet toward execute
    output fetch_pkg::fetch_pkt_t fetch_pkt
);

    // hart owning the current slot
    fetch_pkg::hart_id_t hart_id;

    // pcs of all harts
    fetch_pkg::word_t [fetch_pkg::NUM_HARTS-1:0] pcs;

    // used slot strobe, steps the selector and the bank together
    logic advance;

    // round-robin slot owner
    hart_selector hart_selector_i (
        .CLK     (CLK),
        .nRST    (nRST),
        .advance (advance),
        .hart_id (hart_id)
    );

    // per-hart pcs beside the selector
    pc_bank pc_bank_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .hart_id  (hart_id),
        .advance  (advance),
        .redirect (redirect),
        .pcs      (pcs)
    );

    // memory request and packet register
    fetch_stage fetch_stage_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .hart_id   (hart_id),
        .pcs       (pcs),
        .redirect  (redirect),
        .imem_rsp  (imem_rsp),
        .imem_req  (imem_req),
        .advance   (advance),
        .fetch_pkt (fetch_pkt)
    );

endmodule

//--- testbench/fetch_checker.sv
// fetch front end checker with hart order, pc and instruction prediction
`timescale 1ns/1ps

module fetch_checker (
    input  logic                  CLK,
    input  logic                  nRST,
    // top level ports of the DUT
    input  fetch_pkg::imem_req_t  imem_req,
    input  fetch_pkg::imem_rsp_t  imem_rsp,
    input  fetch_pkg::redirect_t  redirect,
    input  fetch_pkg::fetch_pkt_t fetch_pkt,
    // name of the running table row shown in error lines
    input  logic [8*16-1:0]       test_name,
    // predicted owner of the current fetch slot
    output fetch_pkg::hart_id_t   slot_hart,
    output int unsigned           pkt_count,
    output int unsigned           err_count
);

    // memory model scramble key shared with the testbench memory
    localparam fetch_pkg::word_t RDATA_KEY = 32'h5a5a_c3c3;

    // hart expected in the next packet
    fetch_pkg::hart_id_t exp_hart;
    // expected pc of the next packet of each hart
    fetch_pkg::word_t    exp_pc [fetch_pkg::NUM_HARTS];
    // slot used in the previous cycle makes a packet due now
    logic                pend_used;
    logic                flush;
    logic                used;
    // first edge out of reset has passed
    logic                released;
    int unsigned         errors = 0;
    int unsigned         packets = 0;

    assign pkt_count = packets;
    assign err_count = errors;

    // round-robin successor
    function automatic fetch_pkg::hart_id_t next_hart(input fetch_pkg::hart_id_t h);
        return fetch_pkg::hart_id_t'((int'(h) + 1) % fetch_pkg::NUM_HARTS);
    endfunction

    task automatic check_value(input string what, input fetch_pkg::word_t expected,
                               input fetch_pkg::word_t actual);
        if (expected !== actual) begin
            errors++;
            $display("FAIL %0s %0s: expected %h, actual %h at %0t",
                     test_name, what, expected, actual, $time);
        end
    endtask

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // no fetch request may leave while in reset
            if (imem_req.ren) begin
                errors++;
                $display("memory read enable high during reset at %0t", $time);
            end
            exp_hart  = '0;
            slot_hart = '0;
            pend_used = 1'b0;
            released  = 1'b0;
            for (int h = 0; h < fetch_pkg::NUM_HARTS; h++) begin
                exp_pc[h] = fetch_pkg::RESET_PC;
            end
        end else begin
            // read enable stays high from the second edge out of reset on
            if (released && !imem_req.ren) begin
                errors++;
                $display("memory read enable low while out of reset at %0t", $time);
            end
            released = 1'b1;
            // one packet exactly one edge after each used slot and none after busy or flush
            check_value("valid", fetch_pkg::word_t'(pend_used),
                        fetch_pkg::word_t'(fetch_pkt.valid));
            if (fetch_pkt.valid) begin
                check_value("hart", fetch_pkg::word_t'(exp_hart),
                            fetch_pkg::word_t'(fetch_pkt.hart));
                check_value("pc", exp_pc[exp_hart], fetch_pkt.pc);
                check_value("instr", exp_pc[exp_hart] ^ RDATA_KEY, fetch_pkt.instr);
                packets++;
                exp_pc[exp_hart] = exp_pc[exp_hart] + 32'd4;
                exp_hart = next_hart(exp_hart);
            end
            // request address is the slot owner's pc before any redirect of this cycle
            if (imem_req.ren) begin
                check_value("addr", exp_pc[slot_hart], imem_req.addr);
            end
            // redirect target is what that hart fetches next
            if (redirect.valid) begin
                exp_pc[redirect.hart] = redirect.target;
            end
            // slot model for the cycle that just ended
            flush = redirect.valid && (redirect.hart == slot_hart);
            used = imem_req.ren && !imem_rsp.busy && !flush;
            pend_used = used;
            if (used) begin
                slot_hart = next_hart(slot_hart);
            end
        end
    end

endmodule

//--- testbench/tb_fetch.sv
// fetch front end testbench with clock, reset, memory model and redirect table
`timescale 1ns/1ps

module tb_fetch;

    localparam int unsigned RESET_CYCLES = 4;
    localparam int unsigned NUM_ROWS = 12;
    localparam int unsigned TARGET_PKTS = 60;
    localparam int unsigned WAIT_LIMIT = 300;
    localparam logic [31:0] SEED = 32'heaa6_9fbc;
    // memory returns address xor this key, same key as the checker
    localparam fetch_pkg::word_t RDATA_KEY = 32'h5a5a_c3c3;

    // one row of stimulus, redirect hart is an offset from the fetching hart
    typedef struct packed {
        logic [8*16-1:0]     name;
        logic [7:0]          idle;
        logic                redir;
        fetch_pkg::hart_id_t ofs;
        fetch_pkg::word_t    target;
        logic                hold_busy;
    } stim_row_t;

    logic                  CLK = 1'b0;
    logic                  nRST;
    fetch_pkg::imem_req_t  imem_req;
    fetch_pkg::imem_rsp_t  imem_rsp;
    fetch_pkg::redirect_t  redirect;
    fetch_pkg::fetch_pkt_t fetch_pkt;

    logic [8*16-1:0]     test_name;
    fetch_pkg::hart_id_t slot_hart;
    int unsigned         pkt_count;
    int unsigned         err_count;
    int unsigned         tb_errors = 0;
    stim_row_t           stim_table [NUM_ROWS];

    // 4 ns period
    always #2 CLK = ~CLK;

    fetch_top dut_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .imem_req  (imem_req),
        .imem_rsp  (imem_rsp),
        .redirect  (redirect),
        .fetch_pkt (fetch_pkt)
    );

    fetch_checker checker_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .imem_req  (imem_req),
        .imem_rsp  (imem_rsp),
        .redirect  (redirect),
        .fetch_pkt (fetch_pkt),
        .test_name (test_name),
        .slot_hart (slot_hart),
        .pkt_count (pkt_count),
        .err_count (err_count)
    );

    // offset 0 hits the fetching hart, any other offset a different one
    task automatic load_table();
        stim_table[0]  = '{"reset_order",   8'd12, 1'b0, 2'd0, 32'h0000_0000, 1'b0};
        stim_table[1]  = '{"plain_run",     8'd8,  1'b0, 2'd0, 32'h0000_0000, 1'b0};
        stim_table[2]  = '{"redir_other1",  8'd3,  1'b1, 2'd1, 32'h0000_1000, 1'b0};
        stim_table[3]  = '{"redir_other2",  8'd2,  1'b1, 2'd2, 32'h0000_2000, 1'b0};
        stim_table[4]  = '{"redir_current", 8'd3,  1'b1, 2'd0, 32'h0000_3000, 1'b0};
        stim_table[5]  = '{"busy_redir",    8'd2,  1'b1, 2'd3, 32'h0000_4000, 1'b1};
        stim_table[6]  = '{"busy_redir_cur", 8'd1, 1'b1, 2'd0, 32'h0000_5000, 1'b1};
        stim_table[7]  = '{"back_to_back",  8'd0,  1'b1, 2'd1, 32'h0000_6000, 1'b0};
        stim_table[8]  = '{"again_current", 8'd0,  1'b1, 2'd0, 32'h0000_7000, 1'b0};
        stim_table[9]  = '{"run_after",     8'd10, 1'b0, 2'd0, 32'h0000_0000, 1'b0};
        stim_table[10] = '{"redir_wrap",    8'd4,  1'b1, 2'd2, 32'hffff_fff8, 1'b0};
        stim_table[11] = '{"final_run",     8'd6,  1'b0, 2'd0, 32'h0000_0000, 1'b0};
    endtask

    // one clock of stimulus, everything driven on the falling edge
    task automatic drive_cycle(input logic redir_en, input fetch_pkg::hart_id_t ofs,
                               input fetch_pkg::word_t target, input logic hold_busy);
        logic             busy;
        fetch_pkg::word_t model_word;
        @(negedge CLK);
        // about 30 percent wait states
        busy = hold_busy || (($urandom % 100) < 30);
        model_word = imem_req.addr ^ RDATA_KEY;
        imem_rsp.busy = busy;
        // garbage while busy, so only the completing cycle carries the word
        imem_rsp.rdata = busy ? ~model_word : model_word;
        redirect.valid = redir_en;
        redirect.hart = slot_hart + ofs;
        redirect.target = target;
    endtask

    initial begin
        int unsigned waited;
        nRST = 1'b0;
        imem_rsp = '0;
        redirect = '0;
        test_name = "reset";
        void'($urandom(SEED));
        load_table();
        repeat (RESET_CYCLES) drive_cycle(1'b0, '0, '0, 1'b0);
        nRST = 1'b1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            test_name = stim_table[i].name;
            repeat (stim_table[i].idle) drive_cycle(1'b0, '0, '0, 1'b0);
            if (stim_table[i].redir) begin
                drive_cycle(1'b1, stim_table[i].ofs, stim_table[i].target,
                            stim_table[i].hold_busy);
            end
        end

        // keep running until enough packets have been checked
        test_name = "drain";
        waited = 0;
        while ((pkt_count < TARGET_PKTS) && (waited < WAIT_LIMIT)) begin
            drive_cycle(1'b0, '0, '0, 1'b0);
            waited++;
        end
        if (pkt_count < TARGET_PKTS) begin
            tb_errors++;
            $display("timeout: only %0d of %0d packets seen after %0d cycles",
                     pkt_count, TARGET_PKTS, waited);
        end

        $display("errors: checker %0d, testbench %0d, packets checked %0d",
                 err_count, tb_errors, pkt_count);
        if ((err_count == 0) && (tb_errors == 0)) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
common/fetch_pkg.sv
hdl/hart_selector.sv
hdl/pc_bank.sv
hdl/fetch_stage.sv
hdl/fetch_top.sv
testbench/fetch_checker.sv
testbench/tb_fetch.sv

//--- Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= *** TEST PASSED ***

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# build the simulation executable from the file list
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# output goes to the terminal, status comes from the search for the pass line
run: compile
	./$(SIM_BIN) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
